//--- sources.f
src/lidar_pkg.sv
src/shot_timer.sv
src/spi_master.sv
src/scan_sequencer.sv
src/record_fifo.sv
src/record_uart_tx.sv
src/lidar_top.sv
tb/lidar_assertions.sv
tb/lidar_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module lidar_tb \
  -f sources.f \
  --Mdir build \
  -o lidar_sim

./build/lidar_sim

//--- tb/lidar_tb.sv
module lidar_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import lidar_pkg::*;

  localparam int TOTAL_SHOTS = 20;
  localparam int FIRST_RUN = 16;
  localparam int PAUSE_SHOTS = 3;
  localparam int SILENT_SHOT = 6;
  // 20 pixels, 5 line ends and 2 frame ends
  localparam int EXPECTED_RECS = 27;
  localparam int WATCHDOG_CYCLES = (TOTAL_SHOTS + PAUSE_SHOTS + 10) * SHOT_PERIOD;

  typedef logic [15:0] tof_queue_t[$];
  typedef scan_record_u rec_queue_t[$];

  logic clk = 1'b0;
  logic reset;
  logic pause;
  logic tdc_intb;
  logic tdc_dout;
  logic tdc_start;
  logic spi_sck;
  logic spi_mosi;
  logic tdc_cs;
  logic mems_cs;
  logic serial_tx;

  tof_queue_t   tof_q;
  rec_queue_t   rx_q;
  logic [15:0]  tof_cur;
  int           n_starts = 0;
  int           n_checked = 0;
  int           mems_frames = 0;
  int           tdc_frames = 0;

  lidar_top u_lidar_top (
    .clk       (clk),
    .reset     (reset),
    .pause     (pause),
    .tdc_intb  (tdc_intb),
    .tdc_dout  (tdc_dout),
    .tdc_start (tdc_start),
    .spi_sck   (spi_sck),
    .spi_mosi  (spi_mosi),
    .tdc_cs    (tdc_cs),
    .mems_cs   (mems_cs),
    .serial_tx (serial_tx)
  );

  bind lidar_top lidar_assertions u_lidar_assertions (
    .clk       (clk),
    .reset     (reset),
    .tdc_start (tdc_start),
    .tdc_cs    (tdc_cs),
    .mems_cs   (mems_cs)
  );

  always #5 clk = ~clk;

  task automatic fail_run(string what);
    $display("%s", what);
    $display("Verification failed");
    $fatal(1, "run stopped");
  endtask

  task automatic check_record(scan_record_u got, scan_record_u exp, string name);
    if (got !== exp) begin
      fail_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_word(logic [23:0] got, logic [23:0] exp, string name);
    if (got !== exp) begin
      fail_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_level(logic got, logic exp, string name);
    if (got !== exp) begin
      fail_run($sformatf("mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
    end
  endtask

  // Mirror word for the n-th shot in scan order
  function automatic logic [23:0] mirror_word_at(int n);
    int pt;
    int ln;
    pt = n % POINTS_PER_LINE;
    ln = (n / POINTS_PER_LINE) % LINES_PER_FRAME;
    return {MEMS_WRITE_OP, 8'(pt * X_STEP), 8'(ln * Y_STEP)};
  endfunction

  function automatic rec_queue_t expected_records(tof_queue_t tofs);
    rec_queue_t   recs;
    scan_record_u r;
    int           pt;
    int           ln;
    int           frames;
    pt = 0;
    ln = 0;
    frames = 0;
    foreach (tofs[i]) begin
      r.pixel = '{kind: REC_PIXEL, line: 6'(ln), point: 8'(pt), tof: tofs[i]};
      recs.push_back(r);
      pt++;
      if (pt == POINTS_PER_LINE) begin
        pt = 0;
        ln++;
        r.marker = '{kind: REC_LINE_END, reserved: '0, count: 16'(ln)};
        recs.push_back(r);
        if (ln == LINES_PER_FRAME) begin
          ln = 0;
          frames++;
          r.marker = '{kind: REC_FRAME_END, reserved: '0, count: 16'(frames)};
          recs.push_back(r);
        end
      end
    end
    return recs;
  endfunction

  task automatic wait_for_starts(int n);
    while (n_starts < n) @(posedge clk);
  endtask

  initial begin : stimulus
    reset <= 1'b1;
    pause <= 1'b0;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    wait_for_starts(FIRST_RUN);
    pause <= 1'b1;
    repeat (PAUSE_SHOTS * SHOT_PERIOD) @(posedge clk);
    pause <= 1'b0;
    wait_for_starts(TOTAL_SHOTS);
    // Hold the scan so no further shots start
    pause <= 1'b1;
    while (n_checked < EXPECTED_RECS) @(posedge clk);
    if (mems_frames == TOTAL_SHOTS && tdc_frames == TOTAL_SHOTS - 1) begin
      $display("Verification passed");
      $finish;
    end else begin
      fail_run($sformatf("wrong number of SPI frames, %0d to the mirror and %0d to the TDC",
                         mems_frames, tdc_frames));
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    fail_run("Timeout: the scan did not deliver all records in time");
  end

  // Outputs stay idle from reset until the first shot starts a transfer
  initial begin : idle_check
    @(posedge clk);
    repeat (SHOT_PERIOD + 1) begin
      @(posedge clk);
      check_level(serial_tx, 1'b1, "serial_tx");
      check_level(tdc_cs, 1'b1, "tdc_cs");
      check_level(mems_cs, 1'b1, "mems_cs");
      check_level(spi_sck, 1'b0, "spi_sck");
      check_level(tdc_start, 1'b0, "tdc_start");
    end
  end

  always @(posedge clk) begin
    if (tdc_start) begin
      if (pause) fail_run("tdc_start fired while the scan was paused");
      n_starts <= n_starts + 1;
    end
  end

  // TDC device model with one silent shot
  initial begin : tdc_model
    int shot_idx;
    int delay;
    void'($urandom(32'h5c46));
    shot_idx = 0;
    tdc_intb <= 1'b1;
    forever begin
      @(posedge clk);
      if (tdc_start) begin
        shot_idx++;
        if (shot_idx == SILENT_SHOT) begin
          tof_q.push_back(TOF_NO_ECHO);
        end else begin
          delay = 5 + int'($urandom % 196);
          tof_cur = 16'($urandom);
          tof_q.push_back(tof_cur);
          repeat (delay) @(posedge clk);
          tdc_intb <= 1'b0;
          @(negedge tdc_cs);
          @(posedge clk);
          tdc_intb <= 1'b1;
        end
      end
    end
  end

  // Readout data of zeros for the opcode byte and then the tof
  initial begin : tdc_serializer
    tdc_dout <= 1'b0;
    forever begin
      @(negedge tdc_cs);
      for (int b = 1; b < 24; b++) begin
        @(negedge spi_sck);
        tdc_dout <= (b >= 8) ? tof_cur[23 - b] : 1'b0;
      end
      @(negedge spi_sck);
      tdc_dout <= 1'b0;
    end
  end

  initial begin : spi_monitor
    logic [23:0] word;
    int          nbits;
    nbits = 0;
    forever begin
      @(posedge spi_sck);
      word = {word[22:0], spi_mosi};
      nbits++;
      if (nbits == 24) begin
        nbits = 0;
        if (!mems_cs) begin
          check_word(word, mirror_word_at(mems_frames), "mems word");
          mems_frames++;
        end else if (!tdc_cs) begin
          check_word(word & 24'hFF0000, {TDC_READ_OP, 16'h0000}, "tdc opcode");
          tdc_frames++;
        end else begin
          fail_run("SPI clock toggled with no chip select low");
        end
      end
    end
  end

  // Mid-bit sampling of four bytes per record
  initial begin : uart_monitor
    logic [31:0] word;
    logic [7:0]  data;
    forever begin
      for (int k = 0; k < 4; k++) begin
        @(negedge serial_tx);
        repeat (BAUD_DIV / 2) @(posedge clk);
        if (serial_tx !== 1'b0) fail_run("UART start bit did not stay low");
        for (int b = 0; b < 8; b++) begin
          repeat (BAUD_DIV) @(posedge clk);
          data[b] = serial_tx;
        end
        repeat (BAUD_DIV) @(posedge clk);
        if (serial_tx !== 1'b1) fail_run("UART stop bit was missing");
        word = {word[23:0], data};
      end
      rx_q.push_back(scan_record_u'(word));
    end
  end

  initial begin : compare
    rec_queue_t exp;
    forever begin
      @(posedge clk);
      while (n_checked < rx_q.size()) begin
        exp = expected_records(tof_q);
        if (n_checked >= exp.size()) fail_run("a record arrived that belongs to no shot");
        check_record(rx_q[n_checked], exp[n_checked], $sformatf("record %0d", n_checked));
        n_checked++;
      end
    end
  end

endmodule

//--- tb/lidar_assertions.sv
module lidar_assertions (
  input logic clk,
  input logic reset,
  input logic tdc_start,
  input logic tdc_cs,
  input logic mems_cs
);

  timeunit 1ns;
  timeprecision 1ps;

  // Only one device on the shared bus at a time
  cs_exclusive: assert property (
    @(posedge clk) disable iff (reset) !(!tdc_cs && !mems_cs)
  ) else $error("both SPI chip selects are low");

  start_single_cycle: assert property (
    @(posedge clk) disable iff (reset) tdc_start |=> !tdc_start
  ) else $error("tdc_start lasted more than one cycle");

  // Firing only with the bus quiet
  start_bus_idle: assert property (
    @(posedge clk) disable iff (reset) $rose(tdc_start) |-> (tdc_cs && mems_cs)
  ) else $error("tdc_start rose during an SPI transfer");

endmodule

//--- src/lidar_top.sv
module lidar_top (
  input  logic clk,
  input  logic reset,
  input  logic pause,
  input  logic tdc_intb,
  input  logic tdc_dout,
  output logic tdc_start,
  output logic spi_sck,
  output logic spi_mosi,
  output logic tdc_cs,
  output logic mems_cs,
  output logic serial_tx
);

  import lidar_pkg::*;

  logic         shot;
  logic         spi_req_valid;
  spi_req_t     spi_req;
  logic         spi_done;
  logic [23:0]  spi_rx;
  logic         rec_push;
  scan_record_u rec;
  scan_record_u head;
  logic         empty;
  logic         pop;

  shot_timer u_shot_timer (
    .clk   (clk),
    .reset (reset),
    .pause (pause),
    .shot  (shot)
  );

  scan_sequencer u_scan_sequencer (
    .clk           (clk),
    .reset         (reset),
    .shot          (shot),
    .pause         (pause),
    .tdc_intb      (tdc_intb),
    .spi_done      (spi_done),
    .spi_rx        (spi_rx),
    .spi_req_valid (spi_req_valid),
    .spi_req       (spi_req),
    .tdc_start     (tdc_start),
    .rec_push      (rec_push),
    .rec           (rec)
  );

  // One bus shared by the TDC and the mirror DAC
  spi_master u_spi_master (
    .clk       (clk),
    .reset     (reset),
    .req_valid (spi_req_valid),
    .req       (spi_req),
    .tdc_dout  (tdc_dout),
    .sck       (spi_sck),
    .mosi      (spi_mosi),
    .tdc_cs    (tdc_cs),
    .mems_cs   (mems_cs),
    .done      (spi_done),
    .rx        (spi_rx)
  );

  record_fifo u_record_fifo (
    .clk   (clk),
    .reset (reset),
    .push  (rec_push),
    .din   (rec),
    .pop   (pop),
    .head  (head),
    .empty (empty)
  );

  record_uart_tx u_record_uart_tx (
    .clk   (clk),
    .reset (reset),
    .head  (head),
    .empty (empty),
    .pop   (pop),
    .tx    (serial_tx)
  );

endmodule

//--- src/record_uart_tx.sv
module record_uart_tx (
  input  logic                    clk,
  input  logic                    reset,
  input  lidar_pkg::scan_record_u head,
  input  logic                    empty,
  output logic                    pop,
  output logic                    tx
);

  import lidar_pkg::*;

  localparam int BAUD_W = $clog2(BAUD_DIV);
  localparam logic [BAUD_W-1:0] BAUD_LAST = BAUD_W'(BAUD_DIV - 1);

  logic              busy;
  logic [BAUD_W-1:0] baud_cnt;
  logic [3:0]        bit_cnt;
  logic [1:0]        byte_cnt;
  logic [9:0]        frame_q;
  logic [23:0]       rest_q;

  // Take the head as soon as the line is free
  assign pop = !busy && !empty;

  // Frame of stop, data and start bits shifted out from bit 0
  assign tx = frame_q[0];

  always_ff @(posedge clk) begin
    if (reset) begin
      busy     <= 1'b0;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      byte_cnt <= '0;
      frame_q  <= '1;
    end else if (pop) begin
      busy     <= 1'b1;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      byte_cnt <= '0;
      frame_q  <= {1'b1, head[31:24], 1'b0};
    end else if (busy) begin
      if (baud_cnt == BAUD_LAST) begin
        baud_cnt <= '0;
        if (bit_cnt == 4'd9) begin
          bit_cnt <= '0;
          if (byte_cnt == 2'd3) begin
            busy <= 1'b0;
          end else begin
            byte_cnt <= byte_cnt + 1'b1;
            frame_q  <= {1'b1, rest_q[23:16], 1'b0};
          end
        end else begin
          // Ones fill in behind, so the line idles high after the stop bit
          bit_cnt <= bit_cnt + 1'b1;
          frame_q <= {1'b1, frame_q[9:1]};
        end
      end else begin
        baud_cnt <= baud_cnt + 1'b1;
      end
    end
  end

  // Remaining bytes with the most significant next
  always_ff @(posedge clk) begin
    if (pop) begin
      rest_q <= head[23:0];
    end else if (busy && baud_cnt == BAUD_LAST && bit_cnt == 4'd9) begin
      rest_q <= {rest_q[15:0], 8'h00};
    end
  end

endmodule

//--- src/record_fifo.sv
module record_fifo (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    push,
  input  lidar_pkg::scan_record_u din,
  input  logic                    pop,
  output lidar_pkg::scan_record_u head,
  output logic                    empty
);

  import lidar_pkg::*;

  localparam int DEPTH = 2 ** FIFO_ADDR_W;

  scan_record_u           mem [DEPTH];
  logic [FIFO_ADDR_W-1:0] wr_ptr;
  logic [FIFO_ADDR_W-1:0] rd_ptr;
  logic [FIFO_ADDR_W:0]   count;
  logic                   full;
  logic                   do_push;
  logic                   do_pop;

  assign full    = (count == (FIFO_ADDR_W + 1)'(DEPTH));
  assign empty   = (count == '0);
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;
  assign head    = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= din;
    end
  end

  // Pointers wrap naturally at the power-of-two depth
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;
      if (do_pop) rd_ptr <= rd_ptr + 1'b1;
      if (do_push && !do_pop) count <= count + 1'b1;
      else if (do_pop && !do_push) count <= count - 1'b1;
    end
  end

endmodule

//--- src/scan_sequencer.sv
module scan_sequencer (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    shot,
  input  logic                    pause,
  input  logic                    tdc_intb,
  input  logic                    spi_done,
  input  logic [23:0]             spi_rx,
  output logic                    spi_req_valid,
  output lidar_pkg::spi_req_t     spi_req,
  output logic                    tdc_start,
  output logic                    rec_push,
  output lidar_pkg::scan_record_u rec
);

  import lidar_pkg::*;

  localparam int TMO_W = $clog2(TDC_TIMEOUT);
  localparam logic [TMO_W-1:0] TMO_LAST = TMO_W'(TDC_TIMEOUT - 1);

  typedef enum logic [2:0] {
    S_IDLE,
    S_MIRROR,
    S_FIRE,
    S_WAIT,
    S_READ,
    S_LINE,
    S_FRAME
  } state_e;

  state_e           state;
  logic [7:0]       point;
  logic [5:0]       line;
  logic [15:0]      frame;
  logic [TMO_W-1:0] tmo_cnt;
  logic [23:0]      mirror_word;
  logic             last_point;
  logic             last_line;

  function automatic scan_record_u make_pixel(logic [5:0] ln, logic [7:0] pt,
                                              logic [15:0] tof);
    scan_record_u r;
    r.pixel.kind  = REC_PIXEL;
    r.pixel.line  = ln;
    r.pixel.point = pt;
    r.pixel.tof   = tof;
    return r;
  endfunction

  function automatic scan_record_u make_marker(rec_kind_e kind, logic [15:0] count);
    scan_record_u r;
    r.marker.kind     = kind;
    r.marker.reserved = '0;
    r.marker.count    = count;
    return r;
  endfunction

  // Raster position to DAC word
  assign mirror_word = {MEMS_WRITE_OP, 8'(point * X_STEP), 8'(line * Y_STEP)};
  assign last_point  = (point == 8'(POINTS_PER_LINE - 1));
  assign last_line   = (line == 6'(LINES_PER_FRAME - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      state         <= S_IDLE;
      point         <= '0;
      line          <= '0;
      frame         <= '0;
      tmo_cnt       <= '0;
      spi_req_valid <= 1'b0;
      tdc_start     <= 1'b0;
      rec_push      <= 1'b0;
    end else begin
      spi_req_valid <= 1'b0;
      tdc_start     <= 1'b0;
      rec_push      <= 1'b0;
      case (state)
        S_IDLE: begin
          // Shots during a pause are dropped here
          if (shot && !pause) begin
            spi_req_valid <= 1'b1;
            spi_req       <= '{dev: SPI_MEMS, data: mirror_word};
            state         <= S_MIRROR;
          end
        end
        S_MIRROR: begin
          if (spi_done) begin
            tdc_start <= 1'b1;
            state     <= S_FIRE;
          end
        end
        S_FIRE: begin
          tmo_cnt <= '0;
          state   <= S_WAIT;
        end
        S_WAIT: begin
          if (!tdc_intb) begin
            spi_req_valid <= 1'b1;
            spi_req       <= '{dev: SPI_TDC, data: {TDC_READ_OP, 16'h0000}};
            state         <= S_READ;
          end else if (tmo_cnt == TMO_LAST) begin
            // No echo, so skip the readout
            rec_push <= 1'b1;
            rec      <= make_pixel(line, point, TOF_NO_ECHO);
            if (last_point) begin
              state <= S_LINE;
            end else begin
              point <= point + 1'b1;
              state <= S_IDLE;
            end
          end else begin
            tmo_cnt <= tmo_cnt + 1'b1;
          end
        end
        S_READ: begin
          if (spi_done) begin
            rec_push <= 1'b1;
            rec      <= make_pixel(line, point, spi_rx[15:0]);
            if (last_point) begin
              state <= S_LINE;
            end else begin
              point <= point + 1'b1;
              state <= S_IDLE;
            end
          end
        end
        S_LINE: begin
          rec_push <= 1'b1;
          rec      <= make_marker(REC_LINE_END, 16'(line) + 16'd1);
          if (last_line) begin
            state <= S_FRAME;
          end else begin
            line  <= line + 1'b1;
            point <= '0;
            state <= S_IDLE;
          end
        end
        S_FRAME: begin
          rec_push <= 1'b1;
          rec      <= make_marker(REC_FRAME_END, frame + 16'd1);
          frame    <= frame + 1'b1;
          line     <= '0;
          point    <= '0;
          state    <= S_IDLE;
        end
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

//--- src/spi_master.sv
module spi_master (
  input  logic                clk,
  input  logic                reset,
  input  logic                req_valid,
  input  lidar_pkg::spi_req_t req,
  input  logic                tdc_dout,
  output logic                sck,
  output logic                mosi,
  output logic                tdc_cs,
  output logic                mems_cs,
  output logic                done,
  output logic [23:0]         rx
);

  import lidar_pkg::*;

  localparam int HALF_W = $clog2(SPI_HALF_PERIOD);
  localparam logic [HALF_W-1:0] HALF_LAST = HALF_W'(SPI_HALF_PERIOD - 1);

  logic              busy;
  logic              ending;
  logic [HALF_W-1:0] half_cnt;
  logic [4:0]        bit_cnt;
  logic [23:0]       shift_q;

  // MSB is always on the line, so the first bit is ready before sck rises
  assign mosi = shift_q[23];

  always_ff @(posedge clk) begin
    if (reset) begin
      busy     <= 1'b0;
      ending   <= 1'b0;
      half_cnt <= '0;
      bit_cnt  <= '0;
      shift_q  <= '0;
      sck      <= 1'b0;
      tdc_cs   <= 1'b1;
      mems_cs  <= 1'b1;
      done     <= 1'b0;
    end else begin
      done <= 1'b0;
      if (!busy) begin
        if (req_valid) begin
          busy     <= 1'b1;
          half_cnt <= '0;
          bit_cnt  <= '0;
          shift_q  <= req.data;
          tdc_cs   <= (req.dev != SPI_TDC);
          mems_cs  <= (req.dev != SPI_MEMS);
        end
      end else if (ending) begin
        // One cycle after the last falling edge
        ending  <= 1'b0;
        busy    <= 1'b0;
        done    <= 1'b1;
        tdc_cs  <= 1'b1;
        mems_cs <= 1'b1;
      end else if (half_cnt == HALF_LAST) begin
        half_cnt <= '0;
        sck      <= ~sck;
        if (sck) begin
          // Falling edge
          if (bit_cnt == 5'd23) begin
            ending <= 1'b1;
          end else begin
            bit_cnt <= bit_cnt + 1'b1;
            shift_q <= {shift_q[22:0], 1'b0};
          end
        end
      end else begin
        half_cnt <= half_cnt + 1'b1;
      end
    end
  end

  // Sample on rising edges of sck
  always_ff @(posedge clk) begin
    if (busy && !ending && half_cnt == HALF_LAST && !sck) begin
      rx <= {rx[22:0], tdc_dout};
    end
  end

endmodule

//--- src/shot_timer.sv
module shot_timer (
  input  logic clk,
  input  logic reset,
  input  logic pause,
  output logic shot
);

  import lidar_pkg::*;

  localparam int CNT_W = $clog2(SHOT_PERIOD);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(SHOT_PERIOD - 1);

  logic [CNT_W-1:0] cnt;

  // Count only unpaused cycles so a pause never releases a burst
  always_ff @(posedge clk) begin
    if (reset) begin
      cnt  <= '0;
      shot <= 1'b0;
    end else if (pause) begin
      shot <= 1'b0;
    end else if (cnt == CNT_LAST) begin
      cnt  <= '0;
      shot <= 1'b1;
    end else begin
      cnt  <= cnt + 1'b1;
      shot <= 1'b0;
    end
  end

endmodule

//--- src/lidar_pkg.sv
package lidar_pkg;

  // System clock and shooting rate
  localparam int CLK_FREQ = 50_000_000;
  localparam int SHOT_PERIOD = CLK_FREQ / 12_000;

  // Serial timing in clock cycles
  localparam int SPI_HALF_PERIOD = 4;
  localparam int BAUD_DIV = 12;

  // Longest wait for the TDC interrupt
  localparam int TDC_TIMEOUT = 1000;

  // Raster geometry and DAC steps
  localparam int POINTS_PER_LINE = 4;
  localparam int LINES_PER_FRAME = 2;
  localparam int X_STEP = 40;
  localparam int Y_STEP = 60;

  // Device opcodes
  localparam logic [7:0] MEMS_WRITE_OP = 8'h30;
  localparam logic [7:0] TDC_READ_OP = 8'h8C;

  localparam logic [15:0] TOF_NO_ECHO = 16'hFFFF;

  // 64 record slots
  localparam int FIFO_ADDR_W = 6;

  typedef enum logic [1:0] {
    SPI_TDC  = 2'd1,
    SPI_MEMS = 2'd2
  } spi_dev_e;

  typedef struct packed {
    spi_dev_e    dev;
    logic [23:0] data;
  } spi_req_t;

  typedef enum logic [1:0] {
    REC_PIXEL     = 2'd0,
    REC_LINE_END  = 2'd1,
    REC_FRAME_END = 2'd2
  } rec_kind_e;

  typedef struct packed {
    rec_kind_e   kind;
    logic [5:0]  line;
    logic [7:0]  point;
    logic [15:0] tof;
  } pixel_rec_t;

  typedef struct packed {
    rec_kind_e   kind;
    logic [13:0] reserved;
    logic [15:0] count;
  } marker_rec_t;

  // Kind sits in the top two bits of both views
  typedef union packed {
    pixel_rec_t  pixel;
    marker_rec_t marker;
  } scan_record_u;

endpackage
